/* hdl/activityIndicator.sv */
/* One LED blink per command, paced by slowClock levels.
   Commands during a blink are ignored. */

`default_nettype none

module activityIndicator (
  input  wire  masterClock,
  input  wire  reset,
  input  wire  slowClock,             // asynchronous to masterClock
  input  wire  commandStart,
  output logic rxIndicator
);

  logic [1:0] slowSync;               // two-stage synchronizer
  logic [2:0] blinkState;             // 0 idle, then high low high low

  always_ff @(posedge masterClock)
  begin
    slowSync <= {slowSync[0], slowClock};
  end

  // ------------------------------
  // blink machine
  // ------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      blinkState  <= 3'h0;
      rxIndicator <= 1'b0;
    end
    else
    begin
      case (blinkState)
        3'h0 : if (commandStart) blinkState <= 3'h1;
        3'h1 : if (slowSync[1]) blinkState <= 3'h2;      // wait high
        3'h2 :
          begin
            if (!slowSync[1])         // first low, LED on
            begin
              rxIndicator <= 1'b1;
              blinkState  <= 3'h3;
            end
          end
        3'h3 : if (slowSync[1]) blinkState <= 3'h4;
        3'h4 :
          begin
            if (!slowSync[1])         // second low, LED off
            begin
              rxIndicator <= 1'b0;
              blinkState  <= 3'h0;
            end
          end
        default :
          begin
            blinkState  <= 3'h0;
            rxIndicator <= 1'b0;
          end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/elementStore.sv */
/* 256-entry byte store with valid bits, one metadata byte and an entry count.
   Queries are combinational on the registered fields. */

`default_nettype none

module elementStore
  import sandboxPkg::*;
(
  input  wire        masterClock,
  input  wire        reset,
  input  wire        storeUpdate,     // one cycle per mutation
  input  wire        willWrite,
  input  wire        isMetadata,
  input  wire  [7:0] index,
  input  wire  [7:0] value,
  input  wire  [7:0] metadata,
  input  wire  [7:0] selector,
  output logic       resultBool,
  output logic [7:0] resultValue
);

  // ------------------------------
  // storage
  // ------------------------------
  logic [7:0]            entryValue [storeDepth];
  logic [storeDepth-1:0] entryValid;
  logic [7:0]            metaReg;
  logic [8:0]            entryCount;  // up to 256 valid entries

  // value array
  always_ff @(posedge masterClock)
  begin
    if (storeUpdate && !isMetadata && willWrite)
    begin
      entryValue[index] <= value;
    end
  end

  // valid bits, count and metadata
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      entryValid <= '0;
      metaReg    <= 8'h00;
      entryCount <= 9'd0;
    end
    else if (storeUpdate)
    begin
      if (isMetadata)
      begin
        metaReg <= willWrite ? metadata : 8'h00;
      end
      else if (willWrite)
      begin
        entryValid[index] <= 1'b1;
        if (!entryValid[index])
        begin
          entryCount <= entryCount + 9'd1;   // new entry only
        end
      end
      else if (entryValid[index])       // clearing an invalid entry is a no-op
      begin
        entryValid[index] <= 1'b0;
        entryCount        <= entryCount - 9'd1;
      end
    end
  end

  // ------------------------------
  // query decode
  // ------------------------------
  always_comb
  begin
    case (selector)
      selReadEntry :
        begin
          resultBool  = entryValid[index];
          resultValue = entryValid[index] ? entryValue[index] : 8'h00;
        end
      selReadMeta :
        begin
          resultBool  = |metaReg;
          resultValue = metaReg;
        end
      selCount :
        begin
          resultBool  = |entryCount;
          resultValue = entryCount[7:0];    // low byte only
        end
      default :
        begin
          resultBool  = 1'b0;
          resultValue = 8'h00;
        end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/hostFrameReceiver.sv */
/* Collects five strobed bytes into control byte and data word.
   No framing check; bytes arriving while a frame is pending are dropped. */

`default_nettype none

module hostFrameReceiver
  import sandboxPkg::*;
(
  input  wire        masterClock,
  input  wire        reset,
  input  wire        rxStrobe,        // one cycle per received byte
  input  wire  [7:0] rxByte,
  input  wire        clearDR,         // acknowledge from the process
  output logic       dataReceived,    // frame pending
  output logic [7:0] control,
  output logic [31:0] inputData
);

  // ------------------------------
  // byte position tracking
  // ------------------------------
  logic [2:0] byteCount;              // position of the next byte in the frame
  logic [2:0] laneSel;                // data word lane of the current byte
  logic       takeByte;

  assign takeByte = rxStrobe & ~dataReceived;   // ignore input while pending
  assign laneSel  = byteCount - 3'd1;

  // control state
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      byteCount    <= 3'd0;
      dataReceived <= 1'b0;
    end
    else
    begin
      if (takeByte)
      begin
        if (byteCount == 3'(frameBytes - 1))
        begin
          byteCount    <= 3'd0;
          dataReceived <= 1'b1;       // last byte completes the frame
        end
        else
        begin
          byteCount <= byteCount + 3'd1;
        end
      end
      else if (dataReceived && clearDR)
      begin
        dataReceived <= 1'b0;         // released by the process
      end
    end
  end

  // ------------------------------
  // byte steering
  // ------------------------------
  always_ff @(posedge masterClock)
  begin
    if (takeByte)
    begin
      if (byteCount == 3'd0)
      begin
        control <= rxByte;            // first byte is the control byte
      end
      else
      begin
        inputData[8 * laneSel +: 8] <= rxByte;   // lsb first
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/hostFrameTransmitter.sv */
/* Sends status then outputData lsb first as five consecutive byte strobes.
   No back-pressure; a new request during a frame is ignored. */

`default_nettype none

module hostFrameTransmitter
  import sandboxPkg::*;
(
  input  wire         masterClock,
  input  wire         reset,
  input  wire         transmitData,   // level, rising edge starts a frame
  input  wire  [7:0]  status,
  input  wire  [31:0] outputData,
  output logic        txStrobe,
  output logic [7:0]  txByte
);

  logic        transmitPrev;          // for edge detection
  logic [2:0]  bytesLeft;             // bytes still to send after the current one
  logic [31:0] shiftReg;
  logic        startSend;

  assign startSend = transmitData & ~transmitPrev & (bytesLeft == 3'd0);

  // ------------------------------
  // strobe and byte count
  // ------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      transmitPrev <= 1'b0;
      txStrobe     <= 1'b0;
      bytesLeft    <= 3'd0;
    end
    else
    begin
      transmitPrev <= transmitData;
      if (startSend)
      begin
        txStrobe  <= 1'b1;            // status byte goes out now
        bytesLeft <= 3'(frameBytes - 1);
      end
      else if (bytesLeft != 3'd0)
      begin
        txStrobe  <= 1'b1;
        bytesLeft <= bytesLeft - 3'd1;
      end
      else
      begin
        txStrobe <= 1'b0;
      end
    end
  end

  // payload shift
  always_ff @(posedge masterClock)
  begin
    if (startSend)
    begin
      txByte   <= status;
      shiftReg <= outputData;
    end
    else if (bytesLeft != 3'd0)
    begin
      txByte   <= shiftReg[7:0];      // lsb first
      shiftReg <= {8'h00, shiftReg[31:8]};
    end
  end

endmodule

`default_nettype wire

/* hdl/sandboxPkg.sv */
/* Shared constants for the sandbox host link and element store.
   Field positions assume the data word arrives least significant byte first. */

`default_nettype none

package sandboxPkg;

  // ------------------------------
  // frame layout
  // ------------------------------
  localparam int frameBytes = 5;          // command and response frames alike

  // control byte bits
  localparam int ctrlMutate = 0;          // 1 mutates the store, 0 runs a query
  localparam int ctrlMeta   = 1;          // mutation targets the metadata byte
  localparam int ctrlWrite  = 2;          // write when set, clear otherwise

  // ------------------------------
  // data word fields
  // ------------------------------
  localparam int indexLsb    = 0;         // entry index
  localparam int valueLsb    = 8;         // entry value
  localparam int metaLsb     = 16;        // metadata byte
  localparam int selectorLsb = 24;        // query selector

  // element store
  localparam int storeDepth = 256;        // one entry per index value

  // query selector codes
  localparam logic [7:0] selReadEntry = 8'd0;
  localparam logic [7:0] selReadMeta  = 8'd1;
  localparam logic [7:0] selCount     = 8'd2;

  // response status
  localparam logic [7:0] statusBase = 8'h1e;   // bit 0 carries the result bit

endpackage

`default_nettype wire

/* hdl/sandboxProcess.sv */
/* Command sequencer around the element store. One command at a time;
   the result is held until the receiver drops dataReceived. */

`default_nettype none

module sandboxProcess
  import sandboxPkg::*;
(
  input  wire         masterClock,
  input  wire         reset,
  input  wire         dataReceived,   // command pending
  input  wire  [7:0]  control,
  input  wire  [31:0] inputData,
  output logic        clearDR,        // acknowledge toward the receiver
  output logic        transmitData,   // level, response ready
  output logic [7:0]  status,
  output logic [31:0] outputData,
  output logic        commandStart    // one cycle when a command is taken
);

  // ------------------------------
  // registers
  // ------------------------------
  logic [2:0] state;                  // 0 idle 1 build 2 wait 3 ack 4 release
  logic       isMutating;
  logic       willWrite;
  logic       isMetadata;
  logic       storeUpdate;
  logic [7:0] index;
  logic [7:0] value;
  logic [7:0] metadata;
  logic [7:0] selector;

  // query result from the store
  logic       resultBool;
  logic [7:0] resultValue;

  // ------------------------------
  // sequencer
  // ------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      state        <= 3'h0;
      isMutating   <= 1'b0;
      willWrite    <= 1'b0;
      isMetadata   <= 1'b0;
      storeUpdate  <= 1'b0;
      commandStart <= 1'b0;
      transmitData <= 1'b0;
      clearDR      <= 1'b0;
    end
    else
    begin
      storeUpdate  <= 1'b0;           // both are single-cycle pulses
      commandStart <= 1'b0;
      case (state)
        3'h0 :                        // idle
          begin
            if (dataReceived)
            begin
              isMutating   <= control[ctrlMutate];
              isMetadata   <= control[ctrlMeta];
              willWrite    <= control[ctrlWrite];
              commandStart <= 1'b1;
              state        <= 3'h1;
            end
          end
        3'h1 :                        // build result
          begin
            storeUpdate <= isMutating;
            state       <= 3'h2;
          end
        3'h2 :                        // wait, hold one cycle with the request up
          begin
            transmitData <= 1'b1;
            if (transmitData)
            begin
              state <= 3'h3;
            end
          end
        3'h3 :                        // acknowledge
          begin
            clearDR <= 1'b1;
            state   <= 3'h4;
          end
        3'h4 :                        // await release
          begin
            if (!dataReceived)
            begin
              transmitData <= 1'b0;
              clearDR      <= 1'b0;
              state        <= 3'h0;
            end
          end
        default :
          begin
            state <= 3'h0;
          end
      endcase
    end
  end

  // ------------------------------
  // command fields and result
  // ------------------------------
  always_ff @(posedge masterClock)
  begin
    if (state == 3'h0 && dataReceived)
    begin
      index    <= inputData[indexLsb +: 8];
      value    <= inputData[valueLsb +: 8];
      metadata <= inputData[metaLsb +: 8];
      selector <= inputData[selectorLsb +: 8];
    end
    if (state == 3'h1)
    begin
      if (isMutating)                 // mutations always succeed
      begin
        status     <= {statusBase[7:1], 1'b1};
        outputData <= {inputData[31:8], 8'h00};
      end
      else
      begin
        status     <= {statusBase[7:1], resultBool};
        outputData <= {inputData[31:8], resultValue};
      end
    end
  end

  elementStore elementStore_i (
    .masterClock (masterClock),
    .reset       (reset),
    .storeUpdate (storeUpdate),
    .willWrite   (willWrite),
    .isMetadata  (isMetadata),
    .index       (index),
    .value       (value),
    .metadata    (metadata),
    .selector    (selector),
    .resultBool  (resultBool),
    .resultValue (resultValue)
  );

endmodule

`default_nettype wire

/* hdl/sandboxTop.sv */
/* Sandbox top level. Host bytes arrive and leave as single-cycle strobes.
   The host must wait for a response before sending the next frame. */

`default_nettype none

module sandboxTop (
  input  wire        masterClock,
  input  wire        slowClock,       // LED pacing
  input  wire        reset,
  input  wire        rxStrobe,
  input  wire  [7:0] rxByte,
  output wire        txStrobe,
  output wire  [7:0] txByte,
  output wire        rxIndicator
);

  // ------------------------------
  // internal links
  // ------------------------------
  wire        dataReceived;
  wire        clearDR;
  wire [7:0]  control;
  wire [31:0] inputData;
  wire        transmitData;
  wire [7:0]  status;
  wire [31:0] outputData;
  wire        commandStart;

  hostFrameReceiver hostFrameReceiver_i (
    .masterClock  (masterClock),
    .reset        (reset),
    .rxStrobe     (rxStrobe),
    .rxByte       (rxByte),
    .clearDR      (clearDR),
    .dataReceived (dataReceived),
    .control      (control),
    .inputData    (inputData)
  );

  sandboxProcess sandboxProcess_i (
    .masterClock  (masterClock),
    .reset        (reset),
    .dataReceived (dataReceived),
    .control      (control),
    .inputData    (inputData),
    .clearDR      (clearDR),
    .transmitData (transmitData),
    .status       (status),
    .outputData   (outputData),
    .commandStart (commandStart)
  );

  activityIndicator activityIndicator_i (
    .masterClock  (masterClock),
    .reset        (reset),
    .slowClock    (slowClock),
    .commandStart (commandStart),
    .rxIndicator  (rxIndicator)
  );

  hostFrameTransmitter hostFrameTransmitter_i (
    .masterClock  (masterClock),
    .reset        (reset),
    .transmitData (transmitData),
    .status       (status),
    .outputData   (outputData),
    .txStrobe     (txStrobe),
    .txByte       (txByte)
  );

endmodule

`default_nettype wire

/* src.f */
+incdir+test
hdl/sandboxPkg.sv
hdl/hostFrameReceiver.sv
hdl/elementStore.sv
hdl/sandboxProcess.sv
hdl/activityIndicator.sv
hdl/hostFrameTransmitter.sv
hdl/sandboxTop.sv
test/sandboxTb.sv

/* test/sandboxChecks.svh */
/* Frame-level host tasks and typed compares, included inside sandboxTb.
   All tasks expect to be entered 1 ns after a rising masterClock edge. */

`ifndef SANDBOX_CHECKS_SVH
`define SANDBOX_CHECKS_SVH

// ------------------------------
// host side of the byte link
// ------------------------------
task automatic sendFrame(input logic [7:0] ctrl, input logic [31:0] word);
  logic [7:0] frame [frameBytes];
  int         i;
  frame[0] = ctrl;                    // control byte first
  for (i = 1; i < frameBytes; i++)
  begin
    frame[i] = word[8 * (i - 1) +: 8];   // then lsb first
  end
  for (i = 0; i < frameBytes; i++)
  begin
    rxStrobe = 1'b1;
    rxByte   = frame[i];
    @(posedge masterClock);
    #1;
  end
  rxStrobe = 1'b0;
endtask

task automatic receiveFrame(output logic [7:0] gotStatus, output logic [31:0] gotData);
  int waitCount;
  int i;
  waitCount = 0;
  gotData   = 32'h0;
  while (!txStrobe)                   // wait for the status byte
  begin
    @(posedge masterClock);
    #1;
    waitCount++;
    if (waitCount > rspTimeout)
    begin
      $display("timeout: no response frame from the DUT at %0t", $time);
      stopRun();
    end
  end
  gotStatus = txByte;
  for (i = 0; i < frameBytes - 1; i++)
  begin
    @(posedge masterClock);
    #1;
    if (!txStrobe)
    begin
      $display("response frame ended after %0d bytes at %0t", i + 1, $time);
      stopRun();
    end
    gotData[8 * i +: 8] = txByte;     // lsb first
  end
endtask

// ------------------------------
// compares and timed waits
// ------------------------------
task automatic compareByte(input string name, input logic [7:0] got, input logic [7:0] expected);
  if (got !== expected)
  begin
    $display("ERR t=%0t %s got %h expected %h", $time, name, got, expected);
    stopRun();
  end
endtask

task automatic compareWord(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
  if (got !== expected)
  begin
    $display("ERR t=%0t %s got %h expected %h", $time, name, got, expected);
    stopRun();
  end
endtask

task automatic waitForIndicator(input logic level, input int limit);
  int waitCount;
  waitCount = 0;
  while (rxIndicator !== level)
  begin
    @(posedge masterClock);
    #1;
    waitCount++;
    if (waitCount > limit)
    begin
      $display("timeout: rxIndicator never went to %b at %0t", level, $time);
      stopRun();
    end
  end
endtask

task automatic noResponseWithin(input int cycles);
  int i;
  for (i = 0; i < cycles; i++)
  begin
    @(posedge masterClock);
    #1;
    if (txStrobe)
    begin
      $display("unexpected response frame for dropped bytes at %0t", $time);
      stopRun();
    end
  end
endtask

`endif

/* test/sandboxTb.sv */
/* Directed testbench for sandboxTop with a behavioral model of the store.
   Stops at the first mismatch or timeout. */

`default_nettype none

module sandboxTb
  import sandboxPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int rspTimeout   = 100;  // cycles until the status byte
  localparam int blinkTimeout = 1000; // 100 slowClock periods in masterClock cycles

  // control bytes
  localparam logic [7:0] cmdQuery      = 8'h00;
  localparam logic [7:0] cmdWriteEntry = 8'((1 << ctrlMutate) | (1 << ctrlWrite));
  localparam logic [7:0] cmdClearEntry = 8'(1 << ctrlMutate);
  localparam logic [7:0] cmdWriteMeta  = 8'((1 << ctrlMutate) | (1 << ctrlMeta) | (1 << ctrlWrite));
  localparam logic [7:0] cmdClearMeta  = 8'((1 << ctrlMutate) | (1 << ctrlMeta));

  logic       masterClock;
  logic       slowClock;
  logic       reset;
  logic       rxStrobe;
  logic [7:0] rxByte;
  wire        txStrobe;
  wire  [7:0] txByte;
  wire        rxIndicator;

  integer seed;

  // reference model of the store
  logic [7:0] modelValue [storeDepth];
  logic       modelValid [storeDepth];
  logic [7:0] modelMeta;
  int         modelCount;

  `include "sandboxChecks.svh"

  sandboxTop sandboxTop_i (
    .masterClock (masterClock),
    .slowClock   (slowClock),
    .reset       (reset),
    .rxStrobe    (rxStrobe),
    .rxByte      (rxByte),
    .txStrobe    (txStrobe),
    .txByte      (txByte),
    .rxIndicator (rxIndicator)
  );

  initial
  begin
    masterClock = 1'b0;
    forever #2 masterClock = ~masterClock;
  end

  initial
  begin
    slowClock = 1'b0;
    forever #20 slowClock = ~slowClock;   // LED pacing, 40 ns
  end

  task automatic stopRun();
    $display("Testbench failed");
    $fatal(1, "run stopped");
  endtask

  // ------------------------------
  // model and command helpers
  // ------------------------------
  function automatic logic [31:0] makeWord(logic [7:0] sel, logic [7:0] meta,
                                           logic [7:0] val, logic [7:0] idx);
    return {sel, meta, val, idx};
  endfunction

  task automatic predict(input logic [7:0] ctrl, input logic [31:0] word,
                         output logic [7:0] expStatus, output logic [31:0] expData);
    logic [7:0] idx;
    logic       resBit;
    logic [7:0] resVal;
    idx    = word[indexLsb +: 8];
    resBit = 1'b0;
    resVal = 8'h00;
    if (ctrl[ctrlMutate])
    begin
      resBit = 1'b1;                  // mutation always reports success
      if (ctrl[ctrlMeta])
        modelMeta = ctrl[ctrlWrite] ? word[metaLsb +: 8] : 8'h00;
      else if (ctrl[ctrlWrite])
      begin
        if (!modelValid[idx])
          modelCount++;
        modelValid[idx] = 1'b1;
        modelValue[idx] = word[valueLsb +: 8];
      end
      else if (modelValid[idx])       // only a real change moves the count
      begin
        modelValid[idx] = 1'b0;
        modelCount--;
      end
    end
    else
    begin
      case (word[selectorLsb +: 8])
        selReadEntry :
          begin
            resBit = modelValid[idx];
            resVal = modelValid[idx] ? modelValue[idx] : 8'h00;
          end
        selReadMeta :
          begin
            resBit = (modelMeta != 8'h00);
            resVal = modelMeta;
          end
        selCount :
          begin
            resBit = (modelCount != 0);
            resVal = 8'(modelCount);
          end
        default : ;                   // unknown selector gives 0 and 0
      endcase
    end
    expStatus = {statusBase[7:1], resBit};
    expData   = {word[31:8], resVal};
  endtask

  task automatic runCommand(input logic [7:0] ctrl, input logic [31:0] word);
    logic [7:0]  gotStatus;
    logic [31:0] gotData;
    logic [7:0]  expStatus;
    logic [31:0] expData;
    sendFrame(ctrl, word);
    receiveFrame(gotStatus, gotData);
    predict(ctrl, word, expStatus, expData);
    compareByte("status", gotStatus, expStatus);
    compareWord("outputData", gotData, expData);
  endtask

  task automatic idleCycles(input int n);
    int i;
    for (i = 0; i < n; i++)
    begin
      @(posedge masterClock);
      #1;
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic queryAfterReset();
    runCommand(cmdQuery, makeWord(selCount, 8'h00, 8'h00, 8'h00));
    runCommand(cmdQuery, makeWord(selReadEntry, 8'h00, 8'h00, 8'h00));
    runCommand(cmdQuery, makeWord(selReadEntry, 8'h00, 8'h00, 8'h7f));
    runCommand(cmdQuery, makeWord(selReadEntry, 8'h00, 8'h00, 8'hff));
  endtask

  task automatic writeEntries();
    runCommand(cmdWriteEntry, makeWord(8'h5a, 8'h33, 8'ha5, 8'h10));
    runCommand(cmdWriteEntry, makeWord(8'hc3, 8'h00, 8'h3c, 8'h20));
    runCommand(cmdWriteEntry, makeWord(8'h00, 8'h81, 8'h01, 8'hff));
    runCommand(cmdWriteEntry, makeWord(8'h12, 8'h34, 8'h66, 8'h10));   // overwrite
    runCommand(cmdQuery, makeWord(selReadEntry, 8'h00, 8'h00, 8'h10));
    runCommand(cmdQuery, makeWord(selReadEntry, 8'h00, 8'h00, 8'h20));
    runCommand(cmdQuery, makeWord(selReadEntry, 8'h00, 8'h00, 8'hff));
    runCommand(cmdQuery, makeWord(selReadEntry, 8'h00, 8'h00, 8'h11));
    runCommand(cmdQuery, makeWord(selCount, 8'h00, 8'h00, 8'h00));
  endtask

  task automatic clearEntries();
    runCommand(cmdClearEntry, makeWord(8'h00, 8'h00, 8'h00, 8'h20));   // valid one
    runCommand(cmdQuery, makeWord(selCount, 8'h00, 8'h00, 8'h00));
    runCommand(cmdClearEntry, makeWord(8'h00, 8'h00, 8'h00, 8'h21));   // already invalid
    runCommand(cmdQuery, makeWord(selCount, 8'h00, 8'h00, 8'h00));
    runCommand(cmdQuery, makeWord(selReadEntry, 8'h00, 8'h00, 8'h20));
  endtask

  task automatic writeAndClearMetadata();
    runCommand(cmdQuery, makeWord(selReadMeta, 8'h00, 8'h00, 8'h00));
    runCommand(cmdWriteMeta, makeWord(8'h00, 8'h9c, 8'h00, 8'h00));
    runCommand(cmdQuery, makeWord(selReadMeta, 8'h00, 8'h00, 8'h00));
    runCommand(cmdClearMeta, makeWord(8'h00, 8'h55, 8'h00, 8'h00));
    runCommand(cmdQuery, makeWord(selReadMeta, 8'h00, 8'h00, 8'h00));
    runCommand(cmdQuery, makeWord(8'h03, 8'hee, 8'hdd, 8'h10));       // unknown selector
  endtask

  task automatic driveRandomCommands();
    logic [31:0] r;
    logic [31:0] w;
    int          i;
    for (i = 0; i < 40; i++)
    begin
      r = $random(seed);
      w = $random(seed);
      // small index range so writes, clears and reads collide
      runCommand({5'b0, r[2:0]}, makeWord({6'b0, w[25:24]}, w[23:16], w[15:8], {4'h1, w[3:0]}));
    end
  endtask

  task automatic blinkAndDropExtraBytes();
    logic [7:0]  gotStatus;
    logic [31:0] gotData;
    logic [7:0]  expStatus;
    logic [31:0] expData;
    int          i;
    for (i = 0; i < 3; i++)
    begin
      idleCycles(30);                 // let any earlier blink finish
      fork
        runCommand(cmdQuery, makeWord(selCount, 8'h00, 8'h00, 8'h00));
        begin
          waitForIndicator(1'b1, blinkTimeout);
          waitForIndicator(1'b0, blinkTimeout);
        end
      join
    end
    // a whole extra frame while the command is pending
    sendFrame(cmdQuery, makeWord(selCount, 8'h00, 8'h00, 8'h00));
    fork
      sendFrame(cmdWriteEntry, makeWord(8'h00, 8'h00, 8'hbb, 8'h30));
      receiveFrame(gotStatus, gotData);
    join
    predict(cmdQuery, makeWord(selCount, 8'h00, 8'h00, 8'h00), expStatus, expData);
    compareByte("status", gotStatus, expStatus);
    compareWord("outputData", gotData, expData);
    noResponseWithin(40);
    runCommand(cmdQuery, makeWord(selReadEntry, 8'h00, 8'h00, 8'h30));   // still empty
    runCommand(cmdQuery, makeWord(selCount, 8'h00, 8'h00, 8'h00));
  endtask

  // ------------------------------
  // sequence
  // ------------------------------
  initial
  begin
    reset      = 1'b0;
    rxStrobe   = 1'b0;
    rxByte     = 8'h00;
    seed       = 32'hc014;
    modelMeta  = 8'h00;
    modelCount = 0;
    for (int i = 0; i < storeDepth; i++)
    begin
      modelValid[i] = 1'b0;
      modelValue[i] = 8'h00;
    end
    repeat (2) @(posedge masterClock);
    #1;
    reset = 1'b1;
    idleCycles(2);
    queryAfterReset();
    writeEntries();
    clearEntries();
    writeAndClearMetadata();
    driveRandomCommands();
    blinkAndDropExtraBytes();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
